// File: hdl/bp_cfg.svh
/*
  Sizes and opcodes for the gshare predictor.
  BP_GHR_SIZE must be at least log2 of BP_PHT_SIZE, since the PHT index uses
  that many history bits. Table sizes must be powers of two.
*/
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// ==========================================================
// Widths and table sizes
// ==========================================================

// Address and instruction width
`define BP_XLEN 32

// PHT entries, 2-bit counters
`define BP_PHT_SIZE 256

// BTB entries, direct mapped
`define BP_BTB_SIZE 64

// Global history length in bits
`define BP_GHR_SIZE 8

// Counter value after reset, weakly not taken
`define BP_PHT_INIT 2'd1

// ==========================================================
// RV32 opcodes seen by predecode
// ==========================================================
`define BP_OP_BRANCH 7'b1100011
`define BP_OP_JAL 7'b1101111

`endif

// File: hdl/bp_pkg.sv
/*
  Types shared by the predictor blocks.
  Widths follow the config header.
*/
`include "bp_cfg.svh"

package bp_pkg;

  // Kind of prediction handed back to fetch
  typedef enum logic [1:0] {
    NO_SPEC = 2'd0,
    JUMP    = 2'd1,
    BRANCH  = 2'd2
  } spec_type_e;

  // One pc or target
  typedef logic [`BP_XLEN-1:0] addr_t;

  // One saturating counter, upper bit is the taken prediction
  typedef logic [1:0] pht_ctr_t;

  // ==========================================================
  // Instruction word, read as B-type or J-type
  // ==========================================================
  typedef union packed {
    // Conditional branch layout
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    // JAL layout
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } inst_u;

endpackage

// File: hdl/inst_predecode.sv
/*
  Predecode of the fetched word.
  Only B-type branches and JAL are recognized. JALR and compressed
  instructions are not decoded and give a zero offset.
*/
`include "bp_cfg.svh"

module inst_predecode (
  input  bp_pkg::inst_u inst_i,
  output logic          is_branch_o,
  output logic          is_jal_o,
  output bp_pkg::addr_t offset_o
);

  // Offsets of both formats, formed in parallel
  logic [`BP_XLEN-1:0] b_offset;
  logic [`BP_XLEN-1:0] j_offset;

  // ==========================================================
  // Type detection
  // ==========================================================

  // Opcode sits in the same bits for both views
  assign is_branch_o = (inst_i.b_fmt.opcode == `BP_OP_BRANCH);
  assign is_jal_o    = (inst_i.j_fmt.opcode == `BP_OP_JAL);

  // ==========================================================
  // Immediate assembly
  // ==========================================================

  // B-type, 13-bit offset, bit 0 always zero
  assign b_offset = {
    {(`BP_XLEN - 13){inst_i.b_fmt.imm_12}},
    inst_i.b_fmt.imm_12,
    inst_i.b_fmt.imm_11,
    inst_i.b_fmt.imm_10_5,
    inst_i.b_fmt.imm_4_1,
    1'b0
  };

  // J-type, 21-bit offset
  assign j_offset = {
    {(`BP_XLEN - 21){inst_i.j_fmt.imm_20}},
    inst_i.j_fmt.imm_20,
    inst_i.j_fmt.imm_19_12,
    inst_i.j_fmt.imm_11,
    inst_i.j_fmt.imm_10_1,
    1'b0
  };

  // Offset of the detected kind, zero for anything else
  always_comb begin
    offset_o = '0;
    if (is_branch_o) begin
      offset_o = b_offset;
    end else if (is_jal_o) begin
      offset_o = j_offset;
    end
  end

  // Distinct opcodes in the config header keep the two kinds exclusive
  always_comb begin
    assert final (!(is_branch_o && is_jal_o))
      else $error("Word decoded as branch and JAL at once");
  end

endmodule

// File: hdl/gshare_pht.sv
/*
  Global history register and pattern history table.
  Read is combinational from the current contents. An update writes at the
  clock edge that ends its cycle, indexed with the history from before the shift.
*/
`include "bp_cfg.svh"

module gshare_pht (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  bp_pkg::addr_t rd_pc_i,
  output logic          taken_o,
  input  logic          update_en_i,
  input  bp_pkg::addr_t wr_pc_i,
  input  logic          actual_taken_i
);

  import bp_pkg::*;

  localparam int unsigned IDX_W = $clog2(`BP_PHT_SIZE);

  // History, newest outcome in bit 0
  logic [`BP_GHR_SIZE-1:0] ghr_q;

  // Counter table
  pht_ctr_t pht_q [`BP_PHT_SIZE];

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  // Counter at the write index before the update
  pht_ctr_t wr_ctr;

  // Index needs as many history bits as it has bits
  if (`BP_GHR_SIZE < IDX_W) begin : g_ghr_check
    $error("History shorter than the PHT index");
  end

  // ==========================================================
  // Index and read
  // ==========================================================

  // Bit 0 of the pc carries no information
  assign rd_idx = rd_pc_i[IDX_W:1] ^ ghr_q[IDX_W-1:0];
  assign wr_idx = wr_pc_i[IDX_W:1] ^ ghr_q[IDX_W-1:0];

  assign wr_ctr = pht_q[wr_idx];

  // Upper bit set means taken
  assign taken_o = pht_q[rd_idx][1];

  // ==========================================================
  // Update
  // ==========================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ghr_q <= '0;
      for (int i = 0; i < `BP_PHT_SIZE; i++) begin
        pht_q[i] <= pht_ctr_t'(`BP_PHT_INIT);
      end
    end else if (update_en_i) begin
      // Saturate at 3 and at 0
      if (actual_taken_i && (wr_ctr != 2'b11)) begin
        pht_q[wr_idx] <= wr_ctr + 2'd1;
      end else if (!actual_taken_i && (wr_ctr != 2'b00)) begin
        pht_q[wr_idx] <= wr_ctr - 2'd1;
      end
      // Shift in the resolved outcome
      ghr_q <= {ghr_q[`BP_GHR_SIZE-2:0], actual_taken_i};
    end
  end

  // Unknown history would poison both indices
  a_ghr_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(ghr_q)
  ) else $error("GHR holds unknown bits");

endmodule

// File: hdl/branch_target_buffer.sv
/*
  Direct-mapped BTB with valid bit, tag and target per entry.
  The index takes pc bits just above bit 0 and the tag the bits above the
  index plus 2, so one pc bit is in neither and entries can alias.
*/
`include "bp_cfg.svh"

module branch_target_buffer (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  bp_pkg::addr_t rd_pc_i,
  output logic          hit_o,
  output bp_pkg::addr_t target_o,
  input  logic          fill_i,
  input  bp_pkg::addr_t wr_pc_i,
  input  bp_pkg::addr_t wr_target_i
);

  import bp_pkg::*;

  localparam int unsigned IDX_W   = $clog2(`BP_BTB_SIZE);
  localparam int unsigned TAG_LSB = IDX_W + 2;

  // ==========================================================
  // Storage
  // ==========================================================
  logic                       valid_q  [`BP_BTB_SIZE];
  logic [`BP_XLEN-1:TAG_LSB]  tag_q    [`BP_BTB_SIZE];
  addr_t                      target_q [`BP_BTB_SIZE];

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  // Set by the first fill after reset
  logic any_fill_q;

  assign rd_idx = rd_pc_i[IDX_W:1];
  assign wr_idx = wr_pc_i[IDX_W:1];

  // Lookup
  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_pc_i[`BP_XLEN-1:TAG_LSB]);
  assign target_o = target_q[rd_idx];

  // ==========================================================
  // Fill
  // ==========================================================

  // Valid bits and fill flag
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      any_fill_q <= 1'b0;
      for (int i = 0; i < `BP_BTB_SIZE; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (fill_i) begin
      any_fill_q      <= 1'b1;
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Tag and target
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      tag_q[wr_idx]    <= wr_pc_i[`BP_XLEN-1:TAG_LSB];
      target_q[wr_idx] <= wr_target_i;
    end
  end

  // Empty buffer after reset must miss everywhere
  a_no_hit_before_fill: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !any_fill_q |-> !hit_o
  ) else $error("BTB hit with no fill since reset");

endmodule

// File: hdl/next_pc_select.sv
/*
  Fixed-priority choice of the predicted next pc.
  JAL wins over a branch. An invalid or stalled fetch always gets pc + 4.
*/
module next_pc_select (
  input  logic               fetch_valid_i,
  input  logic               stall_i,
  input  bp_pkg::addr_t      pc_i,
  input  logic               is_branch_i,
  input  logic               is_jal_i,
  input  bp_pkg::addr_t      offset_i,
  input  logic               pht_taken_i,
  input  logic               btb_hit_i,
  input  bp_pkg::addr_t      btb_target_i,
  output bp_pkg::addr_t      spec_pc_o,
  output logic               spec_taken_o,
  output bp_pkg::spec_type_e spec_type_o
);

  import bp_pkg::*;

  // Sequential address
  addr_t seq_pc;

  assign seq_pc = pc_i + addr_t'(4);

  // ==========================================================
  // Priority select
  // ==========================================================
  always_comb begin
    // Default, fall through
    spec_pc_o    = seq_pc;
    spec_taken_o = 1'b0;
    spec_type_o  = NO_SPEC;
    if (fetch_valid_i && !stall_i) begin
      if (is_jal_i) begin
        // Direct jump, always taken
        spec_pc_o    = pc_i + offset_i;
        spec_taken_o = 1'b1;
        spec_type_o  = JUMP;
      end else if (is_branch_i && pht_taken_i && btb_hit_i) begin
        // Needs both a taken counter and a known target
        spec_pc_o    = btb_target_i;
        spec_taken_o = 1'b1;
        spec_type_o  = BRANCH;
      end
    end
  end

  // Redirect only for a live fetch
  always_comb begin
    assert final (!spec_taken_o || (fetch_valid_i && !stall_i))
      else $error("Taken prediction without a valid unstalled fetch");
  end

endmodule

// File: hdl/gshare_bp.sv
/*
  Gshare branch predictor for the fetch stage of an RV32 core.
  Prediction is combinational from the table contents at the start of the cycle.
  Only conditional branches train the tables. A stall blocks every update.
*/
module gshare_bp (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Fetch side
  input  logic               fetch_valid_i,
  input  logic               stall_i,
  input  bp_pkg::addr_t      pc_i,
  input  bp_pkg::inst_u      inst_i,
  // Execute side
  input  logic               ex_branch_i,
  input  logic               ex_pred_taken_i,
  input  logic               spec_hit_i,
  input  bp_pkg::addr_t      ex_pc_i,
  input  bp_pkg::addr_t      pc_target_i,
  // Prediction
  output bp_pkg::addr_t      spec_pc_o,
  output logic               spec_taken_o,
  output bp_pkg::spec_type_e spec_type_o
);

  import bp_pkg::*;

  // Predecode results
  logic  is_branch;
  logic  is_jal;
  addr_t offset;

  // Table lookups
  logic  pht_taken;
  logic  btb_hit;
  addr_t btb_target;

  // Update controls
  logic update_en;
  logic actual_taken;
  logic btb_fill;

  // ==========================================================
  // Update controls from execute
  // ==========================================================
  assign update_en = ex_branch_i && !stall_i;

  // Right and predicted taken, or wrong and predicted not taken
  assign actual_taken = (ex_pred_taken_i == spec_hit_i);

  // Only taken branches need a target
  assign btb_fill = update_en && actual_taken;

  // ==========================================================
  // Blocks
  // ==========================================================
  inst_predecode u_predecode (
    .inst_i      (inst_i),
    .is_branch_o (is_branch),
    .is_jal_o    (is_jal),
    .offset_o    (offset)
  );

  gshare_pht u_pht (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rd_pc_i        (pc_i),
    .taken_o        (pht_taken),
    .update_en_i    (update_en),
    .wr_pc_i        (ex_pc_i),
    .actual_taken_i (actual_taken)
  );

  branch_target_buffer u_btb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_pc_i     (pc_i),
    .hit_o       (btb_hit),
    .target_o    (btb_target),
    .fill_i      (btb_fill),
    .wr_pc_i     (ex_pc_i),
    .wr_target_i (pc_target_i)
  );

  next_pc_select u_select (
    .fetch_valid_i (fetch_valid_i),
    .stall_i       (stall_i),
    .pc_i          (pc_i),
    .is_branch_i   (is_branch),
    .is_jal_i      (is_jal),
    .offset_i      (offset),
    .pht_taken_i   (pht_taken),
    .btb_hit_i     (btb_hit),
    .btb_target_i  (btb_target),
    .spec_pc_o     (spec_pc_o),
    .spec_taken_o  (spec_taken_o),
    .spec_type_o   (spec_type_o)
  );

endmodule

// File: testbench/tb_gshare_bp.sv
/*
  Table-driven test of the gshare predictor.
  Inputs change on the falling edge and outputs are sampled 0.5 ns before the
  rising edge. A model of GHR, PHT and BTB gives the expected branch predictions.
*/
`include "bp_cfg.svh"

module tb_gshare_bp;
  timeunit 1ns;
  timeprecision 1ps;

  import bp_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int BTB_IDX_W    = $clog2(`BP_BTB_SIZE);
  localparam logic [31:0] PC_A  = 32'h0000_1040;
  localparam logic [31:0] TGT_A = 32'h0000_2480;
  // Same PHT and BTB index as PC_A with another tag
  localparam logic [31:0] PC_B  = 32'h0000_2040;
  localparam logic [31:0] PC_B2 = 32'h8000_1040;

  typedef struct packed {
    logic [3:0]  test;
    logic        valid;
    logic        stall;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        is_br;
    logic        ex_br;
    logic        ex_pred;
    logic        ex_hit;
    logic [31:0] ex_pc;
    logic [31:0] ex_tgt;
    logic        use_exp;
    logic [31:0] exp_pc;
    spec_type_e  exp_type;
  } row_t;

  logic clk;
  logic rst_n;
  logic fetch_valid;
  logic stall;
  addr_t pc;
  inst_u inst;
  logic ex_branch;
  logic ex_pred_taken;
  logic spec_hit;
  addr_t ex_pc;
  addr_t pc_target;
  addr_t spec_pc;
  logic spec_taken;
  spec_type_e spec_type;

  row_t rows[$];
  int cycles = 0;
  int limit = 1000;
  int checks = 0;
  int errors = 0;
  int test_checks = 0;
  int test_errors = 0;
  int branch_seen = 0;
  int tag_miss_seen = 0;

  // Reference model state
  logic [`BP_GHR_SIZE-1:0] m_ghr;
  logic [1:0]  m_pht  [`BP_PHT_SIZE];
  logic        m_bv   [`BP_BTB_SIZE];
  logic [31:0] m_btag [`BP_BTB_SIZE];
  logic [31:0] m_btgt [`BP_BTB_SIZE];

  gshare_bp gshare_bp_i (
    .clk_i (clk), .rst_ni (rst_n),
    .fetch_valid_i (fetch_valid), .stall_i (stall), .pc_i (pc), .inst_i (inst),
    .ex_branch_i (ex_branch), .ex_pred_taken_i (ex_pred_taken), .spec_hit_i (spec_hit),
    .ex_pc_i (ex_pc), .pc_target_i (pc_target),
    .spec_pc_o (spec_pc), .spec_taken_o (spec_taken), .spec_type_o (spec_type)
  );

  always #2 clk = ~clk;

  // Run limit from the table length
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Cycle limit of %0d reached before the stimulus table was done", limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ==========================================================
  // Encoders and model lookups
  // ==========================================================
  function automatic logic [31:0] enc_branch(input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], `BP_OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, `BP_OP_JAL};
  endfunction

  function automatic int pht_index(input logic [31:0] a);
    return int'(((a >> 1) ^ 32'(m_ghr)) & (`BP_PHT_SIZE - 1));
  endfunction

  function automatic int btb_index(input logic [31:0] a);
    return int'((a >> 1) & (`BP_BTB_SIZE - 1));
  endfunction

  function automatic logic [31:0] rand_pc();
    return $urandom & 32'hFFFF_FFFC;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1: return "after reset";
      2: return "JAL";
      3: return "training";
      4: return "stall blocks training";
      5: return "tag check";
      default: return "random saturation and history";
    endcase
  endfunction

  // ==========================================================
  // Table construction
  // ==========================================================
  task automatic add_row(input int t, input logic v, input logic s, input logic [31:0] a,
                         input logic eb, input logic ep, input logic eh,
                         input logic [31:0] epc, input logic [31:0] etgt);
    row_t r;
    r = '0;
    r.test = 4'(t);
    r.valid = v;
    r.stall = s;
    r.pc = a;
    r.inst = enc_branch(13'd16);
    r.is_br = 1'b1;
    r.ex_br = eb;
    r.ex_pred = ep;
    r.ex_hit = eh;
    r.ex_pc = epc;
    r.ex_tgt = etgt;
    rows.push_back(r);
  endtask

  // JAL rows carry fixed expectations and may resolve PC_A as taken
  task automatic add_jal(input int t, input logic v, input logic s, input logic [31:0] a,
                         input int off, input logic eb);
    row_t r;
    r = '0;
    r.test = 4'(t);
    r.valid = v;
    r.stall = s;
    r.pc = a;
    r.inst = enc_jal(21'(off));
    r.ex_br = eb;
    r.ex_pred = eb;
    r.ex_hit = eb;
    r.ex_pc = PC_A;
    r.ex_tgt = TGT_A;
    r.use_exp = 1'b1;
    r.exp_pc = (v && !s) ? a + 32'(off) : a + 32'd4;
    r.exp_type = (v && !s) ? JUMP : NO_SPEC;
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] pool [4];
    logic tk;
    logic ep;
    for (int i = 0; i < 4; i++) add_row(1, 1, 0, rand_pc(), 0, 0, 0, 0, 0);
    // Taken resolutions alternate between right and wrong
    for (int i = 0; i < 12; i++) add_row(3, 1, 0, PC_A, 1, i[0], i[0], PC_A, TGT_A);
    for (int i = 0; i < 3; i++) add_row(3, 1, 0, PC_A, 0, 0, 0, 0, 0);
    // Not-taken resolutions under stall
    for (int i = 0; i < 4; i++) add_row(4, 1, 1, PC_A, 1, 1, 0, PC_A, 32'h0);
    for (int i = 0; i < 2; i++) add_row(4, 1, 0, PC_A, 0, 0, 0, 0, 0);
    add_row(5, 1, 0, PC_B, 0, 0, 0, 0, 0);
    add_row(5, 1, 0, PC_B2, 0, 0, 0, 0, 0);
    // ALU word at the trained pc is neither branch nor JAL
    add_row(5, 1, 0, PC_A, 0, 0, 0, 0, 0);
    rows[rows.size() - 1].inst = 32'h0000_0013;
    rows[rows.size() - 1].is_br = 1'b0;
    add_row(5, 1, 0, PC_A, 0, 0, 0, 0, 0);
    add_jal(2, 1, 0, PC_A, 256, 0);
    add_jal(2, 1, 0, 32'h0000_3000, -2048, 1);
    add_jal(2, 0, 0, 32'h0000_3000, -2048, 0);
    add_jal(2, 1, 1, 32'h0000_3000, -2048, 1);
    add_jal(2, 1, 0, 32'h0001_0000, 1048574, 0);
    for (int i = 0; i < 4; i++) pool[i] = rand_pc();
    // Mostly not taken in the first half and mostly taken in the second
    for (int i = 0; i < 40; i++) begin
      tk = (i < 20) ? (($urandom % 8) == 0) : (($urandom % 8) != 0);
      ep = $urandom % 2;
      add_row(6, ($urandom % 8) != 0, ($urandom % 8) == 0,
              (($urandom % 8) == 0) ? rand_pc() : pool[$urandom % 4],
              ($urandom % 8) != 0, ep, ep == tk, pool[$urandom % 4], $urandom & ~32'd1);
    end
  endtask

  // ==========================================================
  // Model, drive and check
  // ==========================================================
  task automatic model_update(input row_t r);
    int pi;
    int bi;
    logic tk;
    if (r.ex_br && !r.stall) begin
      tk = (r.ex_pred == r.ex_hit);
      pi = pht_index(r.ex_pc);
      bi = btb_index(r.ex_pc);
      if (tk && m_pht[pi] != 2'd3) m_pht[pi] = m_pht[pi] + 2'd1;
      else if (!tk && m_pht[pi] != 2'd0) m_pht[pi] = m_pht[pi] - 2'd1;
      if (tk) begin
        m_bv[bi] = 1'b1;
        m_btag[bi] = r.ex_pc >> (BTB_IDX_W + 2);
        m_btgt[bi] = r.ex_tgt;
      end
      m_ghr = {m_ghr[`BP_GHR_SIZE-2:0], tk};
    end
  endtask

  task automatic report_error(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("** Error at %0.1f ns: %s expected %h, got %h", $realtime, name, exp, got);
    errors++;
    test_errors++;
  endtask

  task automatic check_row(input row_t r);
    logic [31:0] e_pc;
    spec_type_e e_type;
    logic pht_t;
    logic btb_h;
    int bi;
    bi = btb_index(r.pc);
    pht_t = m_pht[pht_index(r.pc)][1];
    btb_h = m_bv[bi] && (m_btag[bi] == (r.pc >> (BTB_IDX_W + 2)));
    e_pc = r.pc + 32'd4;
    e_type = NO_SPEC;
    if (r.use_exp) begin
      e_pc = r.exp_pc;
      e_type = r.exp_type;
    end else if (r.valid && !r.stall && r.is_br && pht_t && btb_h) begin
      e_pc = m_btgt[bi];
      e_type = BRANCH;
    end
    if (r.test == 3 && e_type == BRANCH) branch_seen++;
    if (r.test == 5 && pht_t && !btb_h) tag_miss_seen++;
    checks += 3;
    test_checks += 3;
    if (spec_pc !== e_pc) report_error("spec_pc_o", e_pc, spec_pc);
    if (spec_taken !== (e_type != NO_SPEC)) begin
      report_error("spec_taken_o", e_type != NO_SPEC, spec_taken);
    end
    if (spec_type !== e_type) report_error("spec_type_o", e_type, spec_type);
  endtask

  task automatic finish_test(input int t);
    if (t == 3 && branch_seen == 0) begin
      $display("Training never brought the branch to a BRANCH prediction");
      errors++;
      test_errors++;
    end
    if (t == 5 && tag_miss_seen == 0) begin
      $display("No tag check fetch saw a taken PHT counter");
      errors++;
      test_errors++;
    end
    $display("Test %0d %s: %0d checks, %0d errors", t, test_name(t), test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin
    row_t r;
    void'($urandom(91));
    clk = 1'b0;
    rst_n = 1'b0;
    fetch_valid = 1'b0;
    stall = 1'b0;
    pc = '0;
    inst = '0;
    ex_branch = 1'b0;
    ex_pred_taken = 1'b0;
    spec_hit = 1'b0;
    ex_pc = '0;
    pc_target = '0;
    build_table();
    limit = rows.size() + RESET_CYCLES + 20;
    // Empty BTB and weakly not taken counters
    m_ghr = '0;
    for (int i = 0; i < `BP_PHT_SIZE; i++) m_pht[i] = `BP_PHT_INIT;
    for (int i = 0; i < `BP_BTB_SIZE; i++) m_bv[i] = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < rows.size(); n++) begin
      r = rows[n];
      @(negedge clk);
      fetch_valid = r.valid;
      stall = r.stall;
      pc = r.pc;
      inst = r.inst;
      ex_branch = r.ex_br;
      ex_pred_taken = r.ex_pred;
      spec_hit = r.ex_hit;
      ex_pc = r.ex_pc;
      pc_target = r.ex_tgt;
      #1.5;
      check_row(r);
      model_update(r);
      if (n == rows.size() - 1 || rows[n + 1].test != r.test) finish_test(r.test);
    end
    $display("Rows: %0d, checks: %0d, errors: %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+hdl
hdl/bp_pkg.sv
hdl/inst_predecode.sv
hdl/gshare_pht.sv
hdl/branch_target_buffer.sv
hdl/next_pc_select.sv
hdl/gshare_bp.sv
testbench/tb_gshare_bp.sv
